// File: debug_cause_tracker.sv
// ----------------------------------------------------------------------
// Expected debug cause tracker
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module debug_cause_tracker (
  input  logic                         cov_assert_if,
  input  logic                         arst_n_i,
  input  debug_monitor_pkg::retire_t   retire_i,
  input  debug_monitor_pkg::dbg_ctrl_t ctrl_i,
  output debug_monitor_pkg::cause_t    cause_o,
  output logic                         ebreak_hit_o
);

  import debug_monitor_pkg::*;

  logic   is_ebreak;
  logic   is_cebreak;
  logic   trigger_match;
  cause_t cause_q;

  // ----------------------------------------------------------------------
  // Write-back decode
  // ----------------------------------------------------------------------
  // A faulted fetch never executes, so err masks the breakpoint
  assign is_ebreak  = retire_i.valid && !retire_i.err
                      && (retire_i.insn == EBREAK_OPCODE);
  assign is_cebreak = retire_i.valid && !retire_i.err
                      && (retire_i.insn == CEBREAK_OPCODE);

  // Without dcsr.ebreakm the breakpoint traps to M-mode instead
  assign ebreak_hit_o = (is_ebreak || is_cebreak) && ctrl_i.dcsr_ebreakm;

  assign trigger_match = retire_i.valid && ctrl_i.trigger_hit;

  // ----------------------------------------------------------------------
  // Cause priority
  // ----------------------------------------------------------------------
  // haltreq > trigger > ebreak > step and frozen once in debug mode
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cause_q <= CAUSE_NONE;
    end else if (!ctrl_i.debug_mode) begin
      if (ctrl_i.debug_req) begin
        cause_q <= CAUSE_HALTREQ;
      end else if (trigger_match) begin
        cause_q <= CAUSE_TRIGGER;
      end else if (ebreak_hit_o) begin
        cause_q <= CAUSE_EBREAK;
      end else if (ctrl_i.dcsr_step
                   && ((cause_q == CAUSE_NONE) || (cause_q == CAUSE_STEP))) begin
        // Step never overrides a pending higher cause
        cause_q <= CAUSE_STEP;
      end else begin
        cause_q <= CAUSE_NONE;
      end
    end
  end

  assign cause_o = cause_q;

endmodule

`default_nettype wire

// File: debug_entry_checker.sv
// ----------------------------------------------------------------------
// Debug entry checker and counters
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module debug_entry_checker (
  input  logic                           cov_assert_if,
  input  logic                           arst_n_i,
  input  logic                           debug_mode_i,
  input  debug_monitor_pkg::dbg_report_t report_i,
  input  debug_monitor_pkg::cause_t      cause_i,
  input  debug_monitor_pkg::addr_t       dpc_i,
  input  logic                           count_en_i,
  input  logic                           clear_i,
  output debug_monitor_pkg::entry_stat_t stat_o
);

  import debug_monitor_pkg::*;

  logic   debug_mode_q;
  logic   entry;
  logic   mismatch;
  count_t entry_count_q;
  count_t error_count_q;
  cause_t last_cause_q;
  addr_t  last_dpc_q;

  // ----------------------------------------------------------------------
  // Entry detection
  // ----------------------------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      debug_mode_q <= 1'b0;
    end else begin
      debug_mode_q <= debug_mode_i;
    end
  end

  // First cycle in debug mode
  assign entry    = debug_mode_i && !debug_mode_q;
  assign mismatch = (report_i.cause != cause_i) || (report_i.dpc != dpc_i);

  // ----------------------------------------------------------------------
  // Saturating counters where a clear wins over an entry
  // ----------------------------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entry_count_q <= '0;
      error_count_q <= '0;
    end else if (clear_i) begin
      entry_count_q <= '0;
      error_count_q <= '0;
    end else if (entry) begin
      if (entry_count_q != '1) begin
        entry_count_q <= entry_count_q + 1'b1;
      end
      if (count_en_i && mismatch && (error_count_q != '1)) begin
        error_count_q <= error_count_q + 1'b1;
      end
    end
  end

  // Predictions seen at the last entry
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_cause_q <= CAUSE_NONE;
      last_dpc_q   <= '0;
    end else if (entry) begin
      last_cause_q <= cause_i;
      last_dpc_q   <= dpc_i;
    end
  end

  assign stat_o = '{
    entry_count: entry_count_q,
    error_count: error_count_q,
    last_cause:  last_cause_q,
    last_dpc:    last_dpc_q
  };

endmodule

`default_nettype wire

// File: debug_entry_monitor.f
+incdir+.
debug_monitor_pkg.sv
debug_cause_tracker.sv
dpc_predictor.sv
debug_entry_checker.sv
debug_monitor_apb_regs.sv
debug_entry_monitor.sv
debug_entry_monitor_tb.sv

// File: debug_entry_monitor.sv
// ----------------------------------------------------------------------
// Debug entry monitor top level
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module debug_entry_monitor (
  input  logic                           cov_assert_if,
  input  logic                           arst_n_i,
  input  debug_monitor_pkg::retire_t     retire_i,
  input  debug_monitor_pkg::dbg_ctrl_t   ctrl_i,
  input  debug_monitor_pkg::dbg_report_t report_i,
  input  debug_monitor_pkg::apb_req_t    apb_req_i,
  output debug_monitor_pkg::apb_rsp_t    apb_rsp_o
);

  import debug_monitor_pkg::*;

  cause_t      cause;
  logic        ebreak_hit;
  addr_t       dpc;
  logic        count_en;
  logic        clear;
  entry_stat_t stat;

  debug_cause_tracker i_cause_tracker (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .retire_i      (retire_i),
    .ctrl_i        (ctrl_i),
    .cause_o       (cause),
    .ebreak_hit_o  (ebreak_hit)
  );

  dpc_predictor i_dpc_predictor (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .retire_i      (retire_i),
    .debug_mode_i  (ctrl_i.debug_mode),
    .trigger_hit_i (ctrl_i.trigger_hit),
    .ebreak_hit_i  (ebreak_hit),
    .dpc_o         (dpc)
  );

  debug_entry_checker i_entry_checker (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .debug_mode_i  (ctrl_i.debug_mode),
    .report_i      (report_i),
    .cause_i       (cause),
    .dpc_i         (dpc),
    .count_en_i    (count_en),
    .clear_i       (clear),
    .stat_o        (stat)
  );

  debug_monitor_apb_regs i_apb_regs (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n_i),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .stat_i        (stat),
    .count_en_o    (count_en),
    .clear_o       (clear)
  );

endmodule

`default_nettype wire

// File: debug_entry_monitor_tb_model.svh
// ----------------------------------------------------------------------
// Testbench reference model and checks
// ----------------------------------------------------------------------
`ifndef DEBUG_ENTRY_MONITOR_TB_MODEL_SVH
`define DEBUG_ENTRY_MONITOR_TB_MODEL_SVH

logic [31:0] rng_state;
cause_t      m_cause;
addr_t       m_dpc;
logic        m_dm_q;
logic        m_count_en;
count_t      m_entry_count;
count_t      m_error_count;
cause_t      m_last_cause;
addr_t       m_last_dpc;

function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

task automatic abort_run(input string why);
  $display("%s", why);
  $display("Test failed");
  $fatal(1);
endtask

// ----------------------------------------------------------------------
// Typed compares
// ----------------------------------------------------------------------
task automatic check_count(input string name, input count_t got, input count_t exp);
  if (got !== exp) begin
    abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  end
endtask

task automatic check_cause(input string name, input cause_t got, input cause_t exp);
  if (got !== exp) begin
    abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
  if (got !== exp) begin
    abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  end
endtask

task automatic check_slverr(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  end
endtask

// ----------------------------------------------------------------------
// Model
// ----------------------------------------------------------------------
// Unmapped addresses always fail and status registers fail only on a write
function automatic logic expected_slverr(input apb_addr_t addr, input logic write);
  case (addr)
    REG_CTRL, REG_ERROR_COUNT: return 1'b0;
    REG_ENTRY_COUNT, REG_LAST_CAUSE, REG_LAST_DPC: return write;
    default: return 1'b1;
  endcase
endfunction

task automatic reset_model();
  m_cause       = CAUSE_NONE;
  m_dpc         = '0;
  m_dm_q        = 1'b0;
  m_count_en    = 1'b0;
  m_entry_count = '0;
  m_error_count = '0;
  m_last_cause  = CAUSE_NONE;
  m_last_dpc    = '0;
endtask

// One rising edge with the inputs currently driven
task automatic model_step();
  logic ebreak_hit;
  logic entry;
  logic mismatch;
  logic wr;
  ebreak_hit = retire.valid && !retire.err && ctrl.dcsr_ebreakm
               && ((retire.insn == EBREAK_OPCODE) || (retire.insn == CEBREAK_OPCODE));
  entry      = ctrl.debug_mode && !m_dm_q;
  mismatch   = (report.cause != m_cause) || (report.dpc != m_dpc);
  wr         = apb_req.psel && apb_req.penable && apb_req.pwrite
               && !expected_slverr(apb_req.paddr, 1'b1);
  if (wr && (apb_req.paddr == REG_ERROR_COUNT)) begin
    m_entry_count = '0;
    m_error_count = '0;
  end else if (entry) begin
    if (m_entry_count != 16'hffff) m_entry_count = m_entry_count + 16'd1;
    if (m_count_en && mismatch && (m_error_count != 16'hffff)) begin
      m_error_count = m_error_count + 16'd1;
    end
  end
  if (entry) begin
    m_last_cause = m_cause;
    m_last_dpc   = m_dpc;
  end
  if (wr && (apb_req.paddr == REG_CTRL)) m_count_en = apb_req.pwdata[0];
  if (!ctrl.debug_mode) begin
    if (ctrl.debug_req) m_cause = CAUSE_HALTREQ;
    else if (retire.valid && ctrl.trigger_hit) m_cause = CAUSE_TRIGGER;
    else if (ebreak_hit) m_cause = CAUSE_EBREAK;
    else if (ctrl.dcsr_step && ((m_cause == CAUSE_NONE) || (m_cause == CAUSE_STEP))) begin
      m_cause = CAUSE_STEP;
    end else m_cause = CAUSE_NONE;
    if (retire.valid) begin
      m_dpc = (ctrl.trigger_hit || ebreak_hit) ? retire.pc_rdata : retire.pc_wdata;
    end
  end
  m_dm_q = ctrl.debug_mode;
endtask

`endif

// File: debug_entry_monitor_tb.sv
// ----------------------------------------------------------------------
// Debug entry monitor testbench
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module debug_entry_monitor_tb;

  import debug_monitor_pkg::*;

  localparam int NUM_PHASES   = 6;
  localparam int PHASE_CYCLES = 2000;

  logic        cov_assert_if;
  logic        arst_n;
  retire_t     retire;
  dbg_ctrl_t   ctrl;
  dbg_report_t report;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  apb_data_t   unused_rdata;

  `include "debug_entry_monitor_tb_model.svh"

  debug_entry_monitor i_dut (
    .cov_assert_if (cov_assert_if),
    .arst_n_i      (arst_n),
    .retire_i      (retire),
    .ctrl_i        (ctrl),
    .report_i      (report),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #20 cov_assert_if = ~cov_assert_if;
  end

  initial begin
    repeat (NUM_PHASES * PHASE_CYCLES) @(posedge cov_assert_if);
    abort_run("Watchdog expired before all test phases finished");
  end

  // ----------------------------------------------------------------------
  // Cycle and bus helpers
  // ----------------------------------------------------------------------
  task automatic tick();
    model_step();
    @(posedge cov_assert_if);
    #2;
  endtask

  task automatic set_core_idle();
    retire = '0;
    ctrl   = '0;
    report = '0;
  endtask

  // The bus has no wait states, so pready must be up in the access phase
  task automatic apb_transfer(input logic write, input apb_addr_t addr,
                              input apb_data_t wdata, output apb_data_t rdata);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    tick();
    apb_req.penable = 1'b1;
    #1;
    if (!apb_rsp.pready) begin
      abort_run("APB access phase did not see pready");
    end
    rdata = apb_rsp.prdata;
    check_slverr("pslverr", apb_rsp.pslverr, expected_slverr(addr, write));
    tick();
    apb_req = '0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
    apb_transfer(1'b0, addr, '0, rdata);
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t unused;
    apb_transfer(1'b1, addr, wdata, unused);
  endtask

  task automatic check_registers();
    apb_data_t rdata;
    apb_read(REG_CTRL, rdata);
    check_count("ctrl", count_t'(rdata), count_t'(m_count_en));
    apb_read(REG_ENTRY_COUNT, rdata);
    check_count("entry_count", count_t'(rdata), m_entry_count);
    apb_read(REG_ERROR_COUNT, rdata);
    check_count("error_count", count_t'(rdata), m_error_count);
    apb_read(REG_LAST_CAUSE, rdata);
    check_cause("last_cause", cause_t'(rdata), m_last_cause);
    apb_read(REG_LAST_DPC, rdata);
    check_addr("last_dpc", rdata, m_last_dpc);
  endtask

  // ----------------------------------------------------------------------
  // Core emulation
  // ----------------------------------------------------------------------
  // Random retirements followed by a short stay in debug mode
  task automatic random_entry(input int unsigned bad_one_in);
    int          lead;
    logic [31:0] r;
    addr_t       pc;
    lead = 2 + int'(next_rand() % 8);
    repeat (lead) begin
      r  = next_rand();
      pc = next_rand() & 32'hffff_fffc;
      retire.valid      = (r[1:0] != 2'b00);
      retire.pc_rdata   = pc;
      retire.pc_wdata   = r[2] ? pc + 32'd2 : pc + 32'd4;
      retire.insn       = (r[5:3] == 3'd0) ? EBREAK_OPCODE :
                          (r[5:3] == 3'd1) ? CEBREAK_OPCODE : next_rand();
      retire.err        = (r[9:6] == 4'd0);
      ctrl.trigger_hit  = (r[13:10] == 4'd0);
      ctrl.dcsr_step    = (r[16:14] == 3'd0);
      ctrl.dcsr_ebreakm = r[17];
      ctrl.debug_req    = (r[22:18] == 5'd0);
      tick();
    end
    // The report on entry matches the prediction unless spoiled
    set_core_idle();
    ctrl.debug_mode = 1'b1;
    r      = next_rand();
    report = '{cause: m_cause, dpc: m_dpc};
    if ((r % bad_one_in) == 0) begin
      if (r[31]) report.cause = report.cause ^ {r[30:29], 1'b1};
      else report.dpc = report.dpc ^ (32'd1 << r[28:24]);
    end
    repeat (2 + int'(r[3:2])) tick();
    set_core_idle();
    tick();
  endtask

  initial begin
    rng_state = 32'h84da_7b95;
    reset_model();
    set_core_idle();
    apb_req = '0;
    arst_n  = 1'b0;
    repeat (8) @(posedge cov_assert_if);
    #2;
    arst_n = 1'b1;
    check_registers();

    apb_write(REG_CTRL, 32'h1);
    repeat (40) begin
      random_entry(4);
      check_registers();
    end

    // Every report is wrong while counting is off
    apb_write(REG_CTRL, 32'h0);
    repeat (20) begin
      random_entry(1);
      check_registers();
    end

    apb_write(REG_ERROR_COUNT, next_rand());
    check_registers();

    // Unmapped addresses and writes to status registers
    repeat (6) begin
      apb_write(8'h20 | apb_addr_t'(next_rand()), next_rand());
      apb_read(8'h01 | apb_addr_t'(next_rand()), unused_rdata);
    end
    apb_write(REG_ENTRY_COUNT, next_rand());
    apb_write(REG_LAST_CAUSE, next_rand());
    apb_write(REG_LAST_DPC, next_rand());
    check_registers();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: debug_monitor_apb_regs.sv
// ----------------------------------------------------------------------
// Monitor APB register block
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module debug_monitor_apb_regs (
  input  logic                           cov_assert_if,
  input  logic                           arst_n_i,
  input  debug_monitor_pkg::apb_req_t    apb_req_i,
  output debug_monitor_pkg::apb_rsp_t    apb_rsp_o,
  input  debug_monitor_pkg::entry_stat_t stat_i,
  output logic                           count_en_o,
  output logic                           clear_o
);

  import debug_monitor_pkg::*;

  logic      access;
  logic      addr_valid;
  logic      addr_ro;
  logic      err;
  logic      wr_ok;
  logic      count_en_q;
  apb_data_t rdata;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  // Every access phase completes without wait states
  assign access = apb_req_i.psel && apb_req_i.penable;

  always_comb begin
    addr_valid = 1'b1;
    addr_ro    = 1'b0;
    rdata      = '0;
    case (apb_req_i.paddr)
      REG_CTRL: begin
        rdata = apb_data_t'(count_en_q);
      end
      REG_ENTRY_COUNT: begin
        rdata   = apb_data_t'(stat_i.entry_count);
        addr_ro = 1'b1;
      end
      REG_ERROR_COUNT: begin
        rdata = apb_data_t'(stat_i.error_count);
      end
      REG_LAST_CAUSE: begin
        rdata   = apb_data_t'(stat_i.last_cause);
        addr_ro = 1'b1;
      end
      REG_LAST_DPC: begin
        rdata   = stat_i.last_dpc;
        addr_ro = 1'b1;
      end
      default: begin
        addr_valid = 1'b0;
      end
    endcase
  end

  // Unknown address, or a write to a status register
  assign err   = access && (!addr_valid || (apb_req_i.pwrite && addr_ro));
  assign wr_ok = access && apb_req_i.pwrite && !err;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_en_q <= 1'b0;
    end else if (wr_ok && (apb_req_i.paddr == REG_CTRL)) begin
      count_en_q <= apb_req_i.pwdata[0];
    end
  end

  // Any data written to the error count clears both counters
  assign clear_o    = wr_ok && (apb_req_i.paddr == REG_ERROR_COUNT);
  assign count_en_o = count_en_q;

  assign apb_rsp_o = '{
    prdata:  rdata,
    pready:  access,
    pslverr: err
  };

endmodule

`default_nettype wire

// File: debug_monitor_pkg.sv
// ----------------------------------------------------------------------
// Debug entry monitor shared definitions
// ----------------------------------------------------------------------
`default_nettype none

package debug_monitor_pkg;

  // ----------------------------------------------------------------------
  // Widths that carry a meaning
  // ----------------------------------------------------------------------
  // Program counter and dpc values
  typedef logic [31:0] addr_t;
  // Compressed instructions sit in the low half, high half zero
  typedef logic [31:0] insn_t;
  // Same encoding as dcsr.cause
  typedef logic [2:0]  cause_t;
  typedef logic [15:0] count_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Debug cause codes
  localparam cause_t CAUSE_NONE    = 3'd0;
  localparam cause_t CAUSE_EBREAK  = 3'd1;
  localparam cause_t CAUSE_TRIGGER = 3'd2;
  localparam cause_t CAUSE_HALTREQ = 3'd3;
  localparam cause_t CAUSE_STEP    = 3'd4;

  // Breakpoint instruction encodings
  localparam insn_t EBREAK_OPCODE  = 32'h0010_0073;
  localparam insn_t CEBREAK_OPCODE = 32'h0000_9002;

  // APB register map
  localparam apb_addr_t REG_CTRL        = 8'h00;
  localparam apb_addr_t REG_ENTRY_COUNT = 8'h04;
  localparam apb_addr_t REG_ERROR_COUNT = 8'h08;
  localparam apb_addr_t REG_LAST_CAUSE  = 8'h0C;
  localparam apb_addr_t REG_LAST_DPC    = 8'h10;

  // ----------------------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------------------
  // Write-back retirement as seen from the core
  typedef struct packed {
    logic  valid;
    addr_t pc_rdata;
    addr_t pc_wdata;
    insn_t insn;
    logic  err;
  } retire_t;

  // Debug control state of the core
  typedef struct packed {
    logic debug_req;
    logic dcsr_step;
    logic dcsr_ebreakm;
    logic trigger_hit;
    logic debug_mode;
  } dbg_ctrl_t;

  // What the core reports once it sits in debug mode
  typedef struct packed {
    cause_t cause;
    addr_t  dpc;
  } dbg_report_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Checker results for the register block
  typedef struct packed {
    count_t entry_count;
    count_t error_count;
    cause_t last_cause;
    addr_t  last_dpc;
  } entry_stat_t;

endpackage

`default_nettype wire

// File: dpc_predictor.sv
// ----------------------------------------------------------------------
// Debug pc predictor
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dpc_predictor (
  input  logic                       cov_assert_if,
  input  logic                       arst_n_i,
  input  debug_monitor_pkg::retire_t retire_i,
  input  logic                       debug_mode_i,
  input  logic                       trigger_hit_i,
  input  logic                       ebreak_hit_i,
  output debug_monitor_pkg::addr_t   dpc_o
);

  import debug_monitor_pkg::*;

  addr_t dpc_q;
  addr_t dpc_next;
  logic  stay_on_pc;

  // Triggers and ebreaks halt on the instruction itself,
  // everything else resumes at the next pc
  assign stay_on_pc = trigger_hit_i || ebreak_hit_i;
  assign dpc_next   = stay_on_pc ? retire_i.pc_rdata : retire_i.pc_wdata;

  always_ff @(posedge cov_assert_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dpc_q <= '0;
    end else if (retire_i.valid && !debug_mode_i) begin
      dpc_q <= dpc_next;
    end
  end

  // Held through debug mode so the checker sees the entry value
  assign dpc_o = dpc_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the debug entry monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module debug_entry_monitor_tb \
  -f debug_entry_monitor.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vdebug_entry_monitor_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
